/* rtl/cache_lookup.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_lookup (
    input  cache_pkg::word_t     addr,
    input  cache_pkg::set_line_t line,
    input  cache_pkg::way_idx_t  last_used,
    output logic                 pass_through,
    output logic                 hit,
    output cache_pkg::way_idx_t  hit_way,
    output cache_pkg::word_t     hit_word,
    output cache_pkg::tag_t      req_tag,
    output cache_pkg::set_idx_t  req_set,
    output cache_pkg::word_off_t req_off,
    output cache_pkg::way_idx_t  victim_way,
    output logic                 victim_dirty,
    output cache_pkg::tag_t      victim_tag
);
    import cache_pkg::*;

    // address fields
    assign req_tag = addr[WORD_W-1 -: TAG_W];
    assign req_set = addr[OFF_W+2 +: SET_W];
    assign req_off = addr[2 +: OFF_W];

    assign pass_through = addr >= NONCACHE_START;

    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < N_WAYS; w++) begin
            if (line[w][VALID_BIT] && line[w][TAG_LSB +: TAG_W] == req_tag && !pass_through) begin
                hit     = 1'b1;
                hit_way = way_idx_t'(w);
            end
        end
    end

    assign hit_word = line[hit_way][req_off*WORD_W +: WORD_W];

    // victim is the way after the last used one
    assign victim_way   = (last_used == way_idx_t'(N_WAYS-1)) ? '0 : last_used + 1'b1;
    assign victim_dirty = line[victim_way][VALID_BIT] && line[victim_way][DIRTY_BIT];
    assign victim_tag   = line[victim_way][TAG_LSB +: TAG_W];

endmodule

`default_nettype wire

/* rtl/cache_pkg.sv */
`default_nettype none

package cache_pkg;

    localparam int WORD_W      = 32;
    localparam int N_WAYS      = 2;
    localparam int N_SETS      = 8;
    localparam int BLOCK_WORDS = 2;

    localparam int SET_W = $clog2(N_SETS);
    localparam int WAY_W = $clog2(N_WAYS);
    localparam int OFF_W = $clog2(BLOCK_WORDS);
    localparam int TAG_W = WORD_W - SET_W - OFF_W - 2;  // two byte bits

    // frame layout, data words from bit 0 up
    localparam int TAG_LSB   = BLOCK_WORDS * WORD_W;
    localparam int DIRTY_BIT = TAG_LSB + TAG_W;
    localparam int VALID_BIT = DIRTY_BIT + 1;
    localparam int FRAME_W   = VALID_BIT + 1;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [3:0]        byte_en_t;
    typedef logic [SET_W-1:0]  set_idx_t;
    typedef logic [WAY_W-1:0]  way_idx_t;
    typedef logic [OFF_W-1:0]  word_off_t;
    typedef logic [TAG_W-1:0]  tag_t;

    localparam word_t NONCACHE_START = 32'hF000_0000;

    typedef logic [FRAME_W-1:0] frame_t;              // valid, dirty, tag, data
    typedef frame_t [N_WAYS-1:0] set_line_t;          // one sram word

    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        WB,
        FLUSH
    } cache_state_t;

endpackage

`default_nettype wire

/* rtl/cache_sram.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_sram (
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic                 wen,
    input  cache_pkg::set_idx_t  sel,
    input  cache_pkg::set_line_t wdata,
    input  cache_pkg::set_line_t mask,
    output cache_pkg::set_line_t rdata
);
    import cache_pkg::*;

    set_line_t lines [N_SETS];

    assign rdata = lines[sel];  // async read

    // a set mask bit keeps the old bit
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int s = 0; s < N_SETS; s++) begin
                lines[s] <= '0;
            end
        end else if (wen) begin
            lines[sel] <= (lines[sel] & mask) | (wdata & ~mask);
        end
    end

endmodule

`default_nettype wire

/* rtl/flush_walker.sv */
`timescale 1ns/1ps
`default_nettype none

module flush_walker (
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic                 step,
    input  logic                 skip,
    input  logic                 clear,
    output cache_pkg::set_idx_t  set,
    output cache_pkg::way_idx_t  way,
    output cache_pkg::word_off_t word,
    output logic                 finish
);
    import cache_pkg::*;

    logic [SET_W+WAY_W+OFF_W:0] cnt;  // word carries into way, way into set

    assign {finish, set, way, word} = cnt;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            cnt <= '0;
        end else if (clear) begin
            cnt <= '0;
        end else if (skip) begin
            // next frame, word back to 0
            cnt <= {cnt[SET_W+WAY_W+OFF_W:OFF_W] + 1'b1, {OFF_W{1'b0}}};
        end else if (step) begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* rtl/l1_cache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module l1_cache_ctrl (
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic                 flush,
    input  logic                 proc_ren,
    input  logic                 proc_wen,
    input  cache_pkg::word_t     proc_addr,
    input  cache_pkg::word_t     proc_wdata,
    input  cache_pkg::byte_en_t  proc_byte_en,
    output cache_pkg::word_t     proc_rdata,
    output logic                 proc_busy,
    output logic                 mem_ren,
    output logic                 mem_wen,
    output cache_pkg::word_t     mem_addr,
    output cache_pkg::word_t     mem_wdata,
    output cache_pkg::byte_en_t  mem_byte_en,
    input  cache_pkg::word_t     mem_rdata,
    input  logic                 mem_busy,
    input  logic                 pass_through,
    input  logic                 hit,
    input  cache_pkg::way_idx_t  hit_way,
    input  cache_pkg::word_t     hit_word,
    input  cache_pkg::tag_t      req_tag,
    input  cache_pkg::set_idx_t  req_set,
    input  cache_pkg::word_off_t req_off,
    input  cache_pkg::way_idx_t  victim_way,
    input  logic                 victim_dirty,
    input  cache_pkg::tag_t      victim_tag,
    input  cache_pkg::set_line_t sram_rdata,
    output logic                 sram_wen,
    output cache_pkg::set_idx_t  sram_sel,
    output cache_pkg::set_line_t sram_wdata,
    output cache_pkg::set_line_t sram_mask,
    input  cache_pkg::set_idx_t  flush_set,
    input  cache_pkg::way_idx_t  flush_way,
    input  cache_pkg::word_off_t flush_word,
    input  logic                 flush_finish,
    output logic                 walk_step,
    output logic                 walk_skip,
    output logic                 walk_clear,
    output cache_pkg::way_idx_t  last_used,
    output logic                 flush_done
);
    import cache_pkg::*;

    cache_state_t   state, next_state;
    way_idx_t       lru [N_SETS];       // last used way per set
    logic           lru_we;
    logic [OFF_W:0] word_cnt, next_word_cnt;
    tag_t           saved_tag, next_saved_tag;
    set_idx_t       saved_set, next_saved_set;
    word_t          blk_addr, next_blk_addr;
    word_t          lane_bits;          // byte enables widened to bits
    logic           req_moved;
    logic           flush_dirty;

    assign last_used   = lru[req_set];
    assign sram_sel    = (state == FLUSH) ? flush_set : req_set;
    assign proc_rdata  = pass_through ? mem_rdata : hit_word;
    assign req_moved   = {req_tag, req_set} != {saved_tag, saved_set};
    assign flush_dirty = sram_rdata[flush_way][VALID_BIT] && sram_rdata[flush_way][DIRTY_BIT];
    assign walk_clear  = (state != FLUSH) || flush_finish;

    always_comb begin
        for (int b = 0; b < 4; b++) begin
            lane_bits[8*b +: 8] = {8{proc_byte_en[b]}};
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state    <= IDLE;
            word_cnt <= '0;
            for (int s = 0; s < N_SETS; s++) begin
                lru[s] <= '0;
            end
        end else begin
            state    <= next_state;
            word_cnt <= next_word_cnt;
            if (lru_we) begin
                lru[req_set] <= hit_way;
            end
        end
    end

    always_ff @(posedge CLK) begin
        saved_tag <= next_saved_tag;
        saved_set <= next_saved_set;
        blk_addr  <= next_blk_addr;
    end

    always_comb begin
        next_state     = state;
        next_word_cnt  = word_cnt;
        next_saved_tag = saved_tag;
        next_saved_set = saved_set;
        next_blk_addr  = blk_addr;
        lru_we         = 1'b0;
        proc_busy      = 1'b1;
        mem_ren        = 1'b0;
        mem_wen        = 1'b0;
        mem_addr       = blk_addr;
        mem_wdata      = '0;
        mem_byte_en    = '1;            // whole words for fills and write-backs
        sram_wen       = 1'b0;
        sram_wdata     = '0;
        sram_mask      = '1;
        walk_step      = 1'b0;
        walk_skip      = 1'b0;
        flush_done     = 1'b0;

        case (state)
            IDLE: begin
                if (hit && (proc_ren || proc_wen) && !flush) begin
                    proc_busy = 1'b0;
                    lru_we    = 1'b1;
                    if (proc_wen) begin
                        // store hit, merge enabled bytes and mark dirty
                        sram_wen = 1'b1;
                        sram_mask[hit_way][req_off*WORD_W +: WORD_W]  = ~lane_bits;
                        sram_wdata[hit_way][req_off*WORD_W +: WORD_W] = proc_wdata;
                        sram_mask[hit_way][DIRTY_BIT]  = 1'b0;
                        sram_wdata[hit_way][DIRTY_BIT] = 1'b1;
                    end
                end else if (pass_through && !flush) begin
                    mem_ren     = proc_ren;
                    mem_wen     = proc_wen;
                    mem_addr    = proc_addr;
                    mem_byte_en = proc_byte_en;
                    mem_wdata   = proc_wdata & lane_bits;   // other lanes stay zero
                    proc_busy   = mem_busy;
                end else if ((proc_ren || proc_wen) && !flush) begin
                    // miss, remember the request and pick the block
                    next_saved_tag = req_tag;
                    next_saved_set = req_set;
                    next_word_cnt  = '0;
                    if (victim_dirty) begin
                        next_blk_addr = {victim_tag, req_set, {(OFF_W+2){1'b0}}};
                        next_state    = WB;
                    end else begin
                        next_blk_addr = {req_tag, req_set, {(OFF_W+2){1'b0}}};
                        next_state    = FETCH;
                    end
                end
            end

            FETCH: begin
                if (req_moved) begin
                    next_word_cnt = '0;
                    next_state    = IDLE;
                end else if (word_cnt == BLOCK_WORDS) begin
                    // install cycle, data already in place
                    sram_wen = 1'b1;
                    sram_mask[victim_way][VALID_BIT:TAG_LSB]  = '0;
                    sram_wdata[victim_way][VALID_BIT:TAG_LSB] = {2'b10, saved_tag};
                    next_word_cnt = '0;
                    next_state    = IDLE;
                end else begin
                    mem_ren = 1'b1;
                    if (!mem_busy) begin
                        sram_wen = 1'b1;
                        sram_mask[victim_way][VALID_BIT] = 1'b0;   // frame invalid while filling
                        sram_mask[victim_way][word_cnt[OFF_W-1:0]*WORD_W +: WORD_W]  = '0;
                        sram_wdata[victim_way][word_cnt[OFF_W-1:0]*WORD_W +: WORD_W] = mem_rdata;
                        next_word_cnt = word_cnt + 1'b1;
                        next_blk_addr = blk_addr + 32'd4;
                    end
                end
            end

            WB: begin
                if (req_moved) begin
                    next_word_cnt = '0;
                    next_state    = IDLE;
                end else if (word_cnt == BLOCK_WORDS) begin
                    sram_wen = 1'b1;
                    sram_mask[victim_way][DIRTY_BIT] = 1'b0;   // victim now clean
                    next_word_cnt = '0;
                    next_blk_addr = {saved_tag, saved_set, {(OFF_W+2){1'b0}}};
                    next_state    = FETCH;
                end else begin
                    mem_wen   = 1'b1;
                    mem_wdata = sram_rdata[victim_way][word_cnt[OFF_W-1:0]*WORD_W +: WORD_W];
                    if (!mem_busy) begin
                        next_word_cnt = word_cnt + 1'b1;
                        next_blk_addr = blk_addr + 32'd4;
                    end
                end
            end

            FLUSH: begin
                if (flush_finish) begin
                    flush_done = 1'b1;
                    next_state = IDLE;
                end else if (flush_dirty) begin
                    mem_wen   = 1'b1;
                    mem_addr  = {sram_rdata[flush_way][TAG_LSB +: TAG_W], flush_set,
                                 flush_word, 2'b00};
                    mem_wdata = sram_rdata[flush_way][flush_word*WORD_W +: WORD_W];
                    if (!mem_busy) begin
                        walk_step = 1'b1;
                        // last word written, drop the frame
                        if (flush_word == word_off_t'(BLOCK_WORDS-1)) begin
                            sram_wen             = 1'b1;
                            sram_mask[flush_way] = '0;
                        end
                    end
                end else begin
                    sram_wen             = 1'b1;
                    sram_mask[flush_way] = '0;    // nothing to write back
                    walk_skip            = 1'b1;
                end
            end
        endcase

        if (flush) begin
            next_state = FLUSH;
        end
    end

endmodule

`default_nettype wire

/* rtl/l1_cache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module l1_cache_top (
    input  logic                CLK,
    input  logic                nRST,
    input  logic                flush,
    output logic                flush_done,
    input  logic                proc_ren,
    input  logic                proc_wen,
    input  cache_pkg::word_t    proc_addr,
    input  cache_pkg::word_t    proc_wdata,
    input  cache_pkg::byte_en_t proc_byte_en,
    output cache_pkg::word_t    proc_rdata,
    output logic                proc_busy,
    output logic                mem_ren,
    output logic                mem_wen,
    output cache_pkg::word_t    mem_addr,
    output cache_pkg::word_t    mem_wdata,
    output cache_pkg::byte_en_t mem_byte_en,
    input  cache_pkg::word_t    mem_rdata,
    input  logic                mem_busy
);
    import cache_pkg::*;

    set_line_t sram_rdata, sram_wdata, sram_mask;
    set_idx_t  sram_sel;
    logic      sram_wen;
    logic      pass_through, hit, victim_dirty;
    way_idx_t  hit_way, victim_way, last_used;
    word_t     hit_word;
    tag_t      req_tag, victim_tag;
    set_idx_t  req_set;
    word_off_t req_off;
    set_idx_t  flush_set;
    way_idx_t  flush_way;
    word_off_t flush_word;
    logic      flush_finish, walk_step, walk_skip, walk_clear;

    cache_sram sram (
        .CLK   (CLK),
        .nRST  (nRST),
        .wen   (sram_wen),
        .sel   (sram_sel),
        .wdata (sram_wdata),
        .mask  (sram_mask),
        .rdata (sram_rdata)
    );

    cache_lookup lookup (
        .addr         (proc_addr),
        .line         (sram_rdata),
        .last_used    (last_used),
        .pass_through (pass_through),
        .hit          (hit),
        .hit_way      (hit_way),
        .hit_word     (hit_word),
        .req_tag      (req_tag),
        .req_set      (req_set),
        .req_off      (req_off),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag)
    );

    flush_walker walker (
        .CLK    (CLK),
        .nRST   (nRST),
        .step   (walk_step),
        .skip   (walk_skip),
        .clear  (walk_clear),
        .set    (flush_set),
        .way    (flush_way),
        .word   (flush_word),
        .finish (flush_finish)
    );

    // controller port names match the nets above
    l1_cache_ctrl ctrl (.*);

endmodule

`default_nettype wire

/* tb.f */
rtl/cache_pkg.sv
rtl/cache_sram.sv
rtl/cache_lookup.sv
rtl/flush_walker.sv
rtl/l1_cache_ctrl.sv
rtl/l1_cache_top.sv
tests/mem_model.sv
tests/tb_l1_cache.sv

/* tests/mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_model #(
    parameter cache_pkg::word_t INIT_XOR = 32'h0
) (
    input  logic                CLK,
    input  logic                nRST,
    input  logic                ren,
    input  logic                wen,
    input  cache_pkg::word_t    addr,
    input  cache_pkg::word_t    wdata,
    input  cache_pkg::byte_en_t byte_en,
    output cache_pkg::word_t    rdata,
    output logic                busy
);
    import cache_pkg::*;

    localparam int WAIT = 2;    // busy cycles ahead of every word

    word_t words [128];         // 64 cacheable words, then 64 uncached ones
    int    wait_cnt;
    word_t log_addr [$];        // completed writes in order

    // bit 31 picks the uncached half
    function automatic int slot(input word_t a);
        return {25'd0, a[31], a[7:2]};
    endfunction

    assign busy  = (ren || wen) && wait_cnt != WAIT;
    assign rdata = words[slot(addr)];

    always @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wait_cnt <= 0;
            for (int i = 0; i < 128; i++) begin
                words[i] <= ((i >= 64) ? 32'hF000_0000 : 32'h0) + 32'(4 * (i % 64)) ^ INIT_XOR;
            end
        end else if (!(ren || wen)) begin
            wait_cnt <= 0;
        end else if (wait_cnt != WAIT) begin
            wait_cnt <= wait_cnt + 1;
        end else begin
            wait_cnt <= 0;              // word done, next one waits again
            if (wen) begin
                for (int b = 0; b < 4; b++) begin
                    if (byte_en[b]) begin
                        words[slot(addr)][8*b +: 8] <= wdata[8*b +: 8];
                    end
                end
                log_addr.push_back(addr);
            end
        end
    end

endmodule

`default_nettype wire

/* tests/tb_l1_cache.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_l1_cache;
    import cache_pkg::*;

    localparam word_t INIT_XOR  = 32'h5A3C_96E1;
    localparam int    N_OPS     = 300;
    localparam int    N_POST    = 32;   // one read per block after the flush
    localparam int    FLUSH_OPS = 8;    // a full flush costs about eight misses
    localparam int    WATCH_NS  = 10 * (16 + 20 * (N_OPS + N_POST + FLUSH_OPS));
    localparam int    XFER_MAX  = 40;

    logic     CLK = 1'b0;
    logic     nRST, flush, flush_done;
    logic     proc_ren, proc_wen, proc_busy;
    word_t    proc_addr, proc_wdata, proc_rdata;
    byte_en_t proc_byte_en;
    logic     mem_ren, mem_wen, mem_busy;
    word_t    mem_addr, mem_wdata, mem_rdata;
    byte_en_t mem_byte_en;

    logic [31:0] lfsr_state;
    word_t       shadow [128];      // expected memory, same slots as the model
    logic        written [128];
    int          checks, errors, done_cnt;

    // memory bus transfers of the current operation
    int       xfer_n;
    word_t    xfer_addr [XFER_MAX];
    word_t    xfer_data [XFER_MAX];
    logic     xfer_wr [XFER_MAX];
    byte_en_t xfer_be [XFER_MAX];

    always #5 CLK = ~CLK;

    l1_cache_top UUT (.*);

    mem_model #(.INIT_XOR(INIT_XOR)) memory (
        .CLK     (CLK),
        .nRST    (nRST),
        .ren     (mem_ren),
        .wen     (mem_wen),
        .addr    (mem_addr),
        .wdata   (mem_wdata),
        .byte_en (mem_byte_en),
        .rdata   (mem_rdata),
        .busy    (mem_busy)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v          = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    function automatic int slot(input word_t a);
        return {25'd0, a[31], a[7:2]};
    endfunction

    function automatic word_t lane_mask(input byte_en_t be);
        word_t m;
        for (int b = 0; b < 4; b++) begin
            m[8*b +: 8] = be[b] ? 8'hFF : 8'h00;
        end
        return m;
    endfunction

    task automatic check_val(input string name, input word_t exp, input word_t got);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("mismatch %s: expected %h, actual %h", name, exp, got);
        end
    endtask

    task automatic check_true(input logic ok, input string what);
        checks++;
        assert (ok) else begin
            errors++;
            $display("error: %s", what);
        end
    endtask

    // sampled on the falling edge, inputs are settled by then
    always @(negedge CLK) begin
        if (nRST && (mem_ren || mem_wen) && !mem_busy) begin
            if (xfer_n < XFER_MAX) begin
                xfer_addr[xfer_n] = mem_addr;
                xfer_data[xfer_n] = mem_wen ? mem_wdata : mem_rdata;
                xfer_wr[xfer_n]   = mem_wen;
                xfer_be[xfer_n]   = mem_byte_en;
                xfer_n++;
            end
        end
        if (flush_done) done_cnt++;
    end

    // called 1 ns after a rising edge, returns at the same point
    task automatic access(input logic is_wr, input word_t addr, input word_t wdata,
                          input byte_en_t be, output word_t rdata);
        xfer_n       = 0;
        proc_ren     = !is_wr;
        proc_wen     = is_wr;
        proc_addr    = addr;
        proc_wdata   = wdata;
        proc_byte_en = be;
        @(negedge CLK);
        while (proc_busy) @(negedge CLK);
        rdata = proc_rdata;
        @(posedge CLK);
        #1;
        proc_ren = 1'b0;
        proc_wen = 1'b0;
    endtask

    // optional two-word write-back, then a two-word fill of the request block
    task automatic check_miss_traffic(input string name, input word_t addr);
        word_t blk;
        int    base;
        blk  = addr & ~32'h7;
        base = (xfer_n == 4) ? 2 : 0;
        if (xfer_n == 0) return;        // hit
        if (xfer_n != 2 && xfer_n != 4) begin
            check_true(1'b0, $sformatf("%s: %0d bus transfers for %h", name, xfer_n, addr));
            return;
        end
        if (xfer_n == 4) begin
            check_true(xfer_wr[0] && xfer_wr[1] && xfer_addr[0][2:0] == 3'b000
                       && xfer_addr[1] == xfer_addr[0] + 4 && xfer_addr[0] != blk
                       && xfer_addr[0] < NONCACHE_START,
                       $sformatf("%s: bad write-back ahead of fill for %h", name, addr));
            check_val($sformatf("%s_wb0", name), shadow[slot(xfer_addr[0])], xfer_data[0]);
            check_val($sformatf("%s_wb1", name), shadow[slot(xfer_addr[1])], xfer_data[1]);
        end
        for (int i = 0; i < 2; i++) begin
            check_true(!xfer_wr[base+i] && xfer_addr[base+i] == blk + 4*i,
                       $sformatf("%s: fill of %h not at its block addresses", name, addr));
            check_val($sformatf("%s_fill", name), shadow[slot(blk + 4*i)], xfer_data[base+i]);
            if (!written[slot(blk + 4*i)]) begin
                check_val($sformatf("%s_fill_init", name), (blk + 4*i) ^ INIT_XOR,
                          xfer_data[base+i]);
            end
        end
    endtask

    task automatic check_passthrough(input logic is_wr, input word_t addr,
                                     input word_t wdata, input byte_en_t be);
        check_true(xfer_n == 1, $sformatf("pass-through %h made %0d transfers", addr, xfer_n));
        if (xfer_n == 1) begin
            check_val("pt_addr", addr, xfer_addr[0]);
            check_val("pt_byte_en", {28'd0, be}, {28'd0, xfer_be[0]});
            check_true(xfer_wr[0] == is_wr, "pass-through used the wrong strobe");
            if (is_wr) check_val("pt_wdata", wdata & lane_mask(be), xfer_data[0]);
        end
    endtask

    initial begin
        #(WATCH_NS);
        $display("timeout: run still going after %0d ns", WATCH_NS);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin : main
        logic     is_wr, pt;
        word_t    addr, wdata, rdata;
        byte_en_t be;
        nRST = 1'b0;
        flush = 1'b0;
        proc_ren = 1'b0;
        proc_wen = 1'b0;
        proc_addr = '0;
        proc_wdata = '0;
        proc_byte_en = '0;
        lfsr_state = 32'd56;
        {checks, errors, done_cnt, xfer_n} = '0;
        for (int i = 0; i < 128; i++) begin
            shadow[i]  = ((i >= 64) ? NONCACHE_START : 32'h0) + 32'(4 * (i % 64)) ^ INIT_XOR;
            written[i] = 1'b0;
        end
        repeat (16) @(posedge CLK);
        #1 nRST = 1'b1;

        for (int n = 0; n < N_OPS; n++) begin
            pt    = rand_bits(3) == 0;  // about one in eight goes uncached
            is_wr = rand_bits(1);
            addr  = rand_bits(6) << 2;
            be    = rand_bits(4);
            wdata = rand_bits(32);
            if (be == 4'h0) be = 4'hF;
            if (pt) addr = addr | NONCACHE_START;
            access(is_wr, addr, wdata, be, rdata);
            if (pt) check_passthrough(is_wr, addr, wdata, be);
            else check_miss_traffic("random", addr);
            if (!is_wr) begin
                check_val("read", shadow[slot(addr)], rdata);
            end else begin
                shadow[slot(addr)]  = (shadow[slot(addr)] & ~lane_mask(be))
                                      | (wdata & lane_mask(be));
                written[slot(addr)] = 1'b1;
            end
        end

        // flush pulse, then every dirty word must reach memory
        xfer_n   = 0;
        done_cnt = 0;
        flush    = 1'b1;
        @(posedge CLK);
        #1 flush = 1'b0;
        while (done_cnt == 0) @(posedge CLK);
        repeat (4) @(posedge CLK);
        #1;
        check_true(done_cnt == 1, $sformatf("flush_done high for %0d cycles", done_cnt));
        for (int i = 0; i < xfer_n; i++) begin
            check_true(xfer_wr[i], "memory read during flush");
            check_val("flush_wb", shadow[slot(xfer_addr[i])], xfer_data[i]);
        end
        for (int i = 0; i < 128; i++) begin
            if (written[i]) check_val("flush_mem", shadow[i], memory.words[i]);
        end

        // all frames invalid now, so each block read must refill
        for (int b = 0; b < N_POST; b++) begin
            addr = 32'(b * 8);
            access(1'b0, addr, '0, 4'hF, rdata);
            check_true(xfer_n == 2, $sformatf("read of %h after flush made %0d transfers",
                                              addr, xfer_n));
            check_miss_traffic("after_flush", addr);
            check_val("after_flush_read", shadow[slot(addr)], rdata);
        end

        // memory only ever sees writes to blocks the processor wrote
        for (int i = 0; i < memory.log_addr.size(); i++) begin
            addr = memory.log_addr[i];
            check_true(written[slot(addr)] || written[slot(addr ^ 32'h4)],
                       $sformatf("memory write to never-written block at %h", addr));
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
